//--- logic/dvi_pkg.sv
// TMDS word width, control characters, lane indices and disparity type for the DVI RTL and bench
package dvi_pkg;

// Bits in one encoded TMDS character
localparam int TMDS_W = 10;

// Control characters sent while de is low, selected by {c1, c0}
// Bit 0 is the first bit on the wire
localparam logic [TMDS_W-1:0] CTRL_00 = 10'b1101010100;
localparam logic [TMDS_W-1:0] CTRL_01 = 10'b0010101011;
localparam logic [TMDS_W-1:0] CTRL_10 = 10'b0101010100;
localparam logic [TMDS_W-1:0] CTRL_11 = 10'b1010101011;

// Clock lane character with bits 0 to 4 high, so the lane is high for the
// first half of each pixel period
localparam logic [TMDS_W-1:0] CLK_LANE_WORD = 10'b00000_11111;

// Channel and lane numbering, shared by the encoder array and the
// four-lane output bus
localparam int CH_BLUE  = 0;
localparam int CH_GREEN = 1;
localparam int CH_RED   = 2;
localparam int LANE_CLK = 3;

// Running disparity in units of ones minus zeros
typedef logic signed [4:0] disparity_t;

endpackage

//--- logic/video_timing.sv
// Raster timing generator with registered de and sync outputs and an eight-bar colour pattern
`timescale 1ns/10ps

module video_timing #(
    parameter int H_ACTIVE  = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_ACTIVE  = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter bit HSYNC_POS = 1'b0,
    parameter bit VSYNC_POS = 1'b0
) (
    input  logic        clk_i,
    input  logic        rst_i,

    output logic        de_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic [23:0] pixel_o // {r[23:16], g[15:8], b[7:0]}
);

localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
localparam int HW      = $clog2(H_TOTAL + 1);
localparam int VW      = $clog2(V_TOTAL + 1);
localparam int BAR_W   = H_ACTIVE / 8;
localparam int BW      = (BAR_W > 1) ? $clog2(BAR_W) : 1;

// Each line and frame starts with active video, then front porch, sync, back porch
localparam logic [HW-1:0] H_LAST   = HW'(H_TOTAL - 1);
localparam logic [HW-1:0] H_ACT    = HW'(H_ACTIVE);
localparam logic [HW-1:0] HS_BEGIN = HW'(H_ACTIVE + H_FRONT);
localparam logic [HW-1:0] HS_END   = HW'(H_ACTIVE + H_FRONT + H_SYNC);
localparam logic [VW-1:0] V_LAST   = VW'(V_TOTAL - 1);
localparam logic [VW-1:0] V_ACT    = VW'(V_ACTIVE);
localparam logic [VW-1:0] VS_BEGIN = VW'(V_ACTIVE + V_FRONT);
localparam logic [VW-1:0] VS_END   = VW'(V_ACTIVE + V_FRONT + V_SYNC);
localparam logic [BW-1:0] BAR_LAST = BW'(BAR_W - 1);

logic [HW-1:0] h_cnt;
logic [VW-1:0] v_cnt;
logic [BW-1:0] bar_cnt;
logic [2:0]    bar_idx;

logic h_active;
logic v_active;
logic line_end;

assign h_active = (h_cnt < H_ACT);
assign v_active = (v_cnt < V_ACT);
assign line_end = (h_cnt == H_LAST);

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        h_cnt <= '0;
        v_cnt <= '0;
    end else if (line_end) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
    end else begin
        h_cnt <= h_cnt + 1'b1;
    end
end

// Bar position within the line, kept in step with h_cnt
always_ff @(posedge clk_i) begin
    if (rst_i || line_end) begin
        bar_cnt <= '0;
        bar_idx <= '0;
    end else if (h_active) begin
        if (bar_cnt == BAR_LAST) begin
            bar_cnt <= '0;
            bar_idx <= bar_idx + 1'b1;
        end else begin
            bar_cnt <= bar_cnt + 1'b1;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        de_o    <= 1'b0;
        hsync_o <= ~HSYNC_POS;
        vsync_o <= ~VSYNC_POS;
    end else begin
        de_o    <= h_active && v_active;
        hsync_o <= (h_cnt >= HS_BEGIN && h_cnt < HS_END) ? HSYNC_POS : ~HSYNC_POS;
        vsync_o <= (v_cnt >= VS_BEGIN && v_cnt < VS_END) ? VSYNC_POS : ~VSYNC_POS;
    end
end

// Bars run white, yellow, cyan, green, magenta, red, blue, black.
// Red is lit where bit 1 of the index is clear, green where bit 2 is
// clear and blue where bit 0 is clear
always_ff @(posedge clk_i) begin
    if (h_active && v_active) begin
        pixel_o <= {{8{~bar_idx[1]}}, {8{~bar_idx[2]}}, {8{~bar_idx[0]}}};
    end else begin
        pixel_o <= 24'h000000;
    end
end

endmodule

//--- logic/tmds_encoder.sv
// One TMDS channel encoder, two pixel clocks from data and control inputs to a 10-bit character
`timescale 1ns/10ps

module tmds_encoder (
    input  logic                       clk_i,
    input  logic                       rst_i,

    input  logic                       de_i,
    input  logic                       c1_i,
    input  logic                       c0_i,
    input  logic [7:0]                 d_i,

    output logic [dvi_pkg::TMDS_W-1:0] q_o
);

import dvi_pkg::*;

// Stage 1 decision and transition-minimised word
logic [3:0] d_ones;
logic       use_xnor;
logic [8:0] q_m;
logic [3:0] q_m_ones;

logic [8:0] q_m_r;
logic [3:0] q_m_ones_r;
logic       de_r;
logic       c1_r;
logic       c0_r;

// Stage 2 DC balancing
disparity_t        disparity;
disparity_t        balance;
disparity_t        disparity_nx;
logic [TMDS_W-1:0] q_nx;

always_comb begin
    d_ones = '0;
    for (int i = 0; i < 8; i++) begin
        d_ones = d_ones + 4'(d_i[i]);
    end
end

// XNOR chaining keeps the transition count down for bytes with many ones
assign use_xnor = (d_ones > 4'd4) || (d_ones == 4'd4 && !d_i[0]);

always_comb begin
    q_m[0] = d_i[0];
    for (int i = 1; i < 8; i++) begin
        q_m[i] = use_xnor ? ~(q_m[i-1] ^ d_i[i]) : (q_m[i-1] ^ d_i[i]);
    end
    q_m[8] = ~use_xnor;

    q_m_ones = '0;
    for (int i = 0; i < 8; i++) begin
        q_m_ones = q_m_ones + 4'(q_m[i]);
    end
end

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        de_r <= 1'b0;
        c1_r <= 1'b0;
        c0_r <= 1'b0;
    end else begin
        de_r <= de_i;
        c1_r <= c1_i;
        c0_r <= c0_i;
    end
end

always_ff @(posedge clk_i) begin
    q_m_r      <= q_m;
    q_m_ones_r <= q_m_ones;
end

// Ones minus zeros of the low byte, 2*n1 - 8, always within -8..8
assign balance = disparity_t'({q_m_ones_r, 1'b0} - 5'd8);

always_comb begin
    q_nx         = CTRL_00;
    disparity_nx = disparity;

    if (!de_r) begin
        case ({c1_r, c0_r})
            2'b00: q_nx = CTRL_00;
            2'b01: q_nx = CTRL_01;
            2'b10: q_nx = CTRL_10;
            2'b11: q_nx = CTRL_11;
        endcase
        disparity_nx = '0;
    end else if (disparity == '0 || balance == '0) begin
        // No bias either way, so bit 9 just flags whether the byte was inverted
        if (q_m_r[8]) begin
            q_nx         = {2'b01, q_m_r[7:0]};
            disparity_nx = disparity + balance;
        end else begin
            q_nx         = {2'b10, ~q_m_r[7:0]};
            disparity_nx = disparity - balance;
        end
    end else if (disparity[4] == balance[4]) begin
        // Both are nonzero here and share a sign, so invert to pull back toward zero
        q_nx         = {1'b1, q_m_r[8], ~q_m_r[7:0]};
        disparity_nx = disparity - balance + (q_m_r[8] ? disparity_t'(2) : disparity_t'(0));
    end else begin
        q_nx         = {1'b0, q_m_r[8], q_m_r[7:0]};
        disparity_nx = disparity + balance - (q_m_r[8] ? disparity_t'(0) : disparity_t'(2));
    end
end

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        q_o       <= CTRL_00;
        disparity <= '0;
    end else begin
        q_o       <= q_nx;
        disparity <= disparity_nx;
    end
end

endmodule

//--- logic/tmds_serializer.sv
// TMDS serializer that loads a 10-bit character once per pixel and shifts out two bits per fast clock
`timescale 1ns/10ps

module tmds_serializer (
    input  logic                       clk_i,
    input  logic                       clk_5x_i,
    input  logic                       rst_i,

    input  logic [dvi_pkg::TMDS_W-1:0] par_i,
    output logic [1:0]                 ser_o // bit 0 goes out first
);

import dvi_pkg::*;

logic              tog;
logic              tog_5x;
logic              rst_meta;
logic              rst_5x;
logic [2:0]        phase;
logic              load;
logic [TMDS_W-1:0] shift;

// Toggles on every pixel clock edge so the fast domain can find pixel boundaries
always_ff @(posedge clk_i) begin
    if (rst_i) begin
        tog <= 1'b0;
    end else begin
        tog <= ~tog;
    end
end

// Two-stage reset synchroniser and the fast copy of the toggle
always_ff @(posedge clk_5x_i) begin
    rst_meta <= rst_i;
    rst_5x   <= rst_meta;
    tog_5x   <= tog;
end

// The toggle change is seen one fast cycle after a pixel edge.
// Counting 1 to 4 from there lands the load on the next aligned edge
always_ff @(posedge clk_5x_i) begin
    if (rst_5x) begin
        phase <= '0;
    end else if (tog != tog_5x) begin
        phase <= 3'd1;
    end else if (phase == 3'd4) begin
        phase <= '0;
    end else if (phase != '0) begin
        phase <= phase + 1'b1;
    end
end

assign load = (phase == 3'd4);

// par_i still holds the previous pixel's character on the aligned edge
always_ff @(posedge clk_5x_i) begin
    if (rst_5x) begin
        shift <= '0;
    end else if (load) begin
        shift <= par_i;
    end else begin
        shift <= {2'b00, shift[TMDS_W-1:2]};
    end
end

assign ser_o = shift[1:0];

endmodule

//--- logic/dvi_tx.sv
// DVI transmitter with three TMDS channel encoders, four lane serializers and the clock lane pattern
`timescale 1ns/10ps

module dvi_tx (
    input  logic            clk_i,
    input  logic            clk_5x_i,
    input  logic            rst_i,

    input  logic            de_i,
    input  logic            hsync_i,
    input  logic            vsync_i,
    input  logic [23:0]     pixel_i, // {r[23:16], g[15:8], b[7:0]}

    // Lanes {CLK, RED, GREEN, BLUE}, two bits per fast cycle
    output logic [3:0][1:0] tmds_o
);

import dvi_pkg::*;

logic [2:0]             enc_c1;
logic [2:0]             enc_c0;
logic [2:0][TMDS_W-1:0] enc_word;
logic [3:0][TMDS_W-1:0] lane_word;

// Sync rides on the blue channel, green and red send CTRL_00 in blanking
always_comb begin
    enc_c1          = '0;
    enc_c0          = '0;
    enc_c1[CH_BLUE] = vsync_i;
    enc_c0[CH_BLUE] = hsync_i;
end

// Instance i takes pixel_i[8*i +: 8], matching the channel numbering
tmds_encoder tmds_encoder [2:0] (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .de_i  ({3{de_i}}),
    .c1_i  (enc_c1),
    .c0_i  (enc_c0),
    .d_i   (pixel_i),
    .q_o   (enc_word)
);

assign lane_word[CH_BLUE]  = enc_word[CH_BLUE];
assign lane_word[CH_GREEN] = enc_word[CH_GREEN];
assign lane_word[CH_RED]   = enc_word[CH_RED];
assign lane_word[LANE_CLK] = CLK_LANE_WORD;

tmds_serializer tmds_serializer [3:0] (
    .clk_i    (clk_i),
    .clk_5x_i (clk_5x_i),
    .rst_i    (rst_i),
    .par_i    (lane_word),
    .ser_o    (tmds_o)
);

endmodule

//--- logic/dvi_system.sv
// Top level joining the raster and colour-bar generator to the DVI transmitter
`timescale 1ns/10ps

module dvi_system #(
    parameter int H_ACTIVE  = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_ACTIVE  = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter bit HSYNC_POS = 1'b0,
    parameter bit VSYNC_POS = 1'b0
) (
    input  logic            clk_i,
    input  logic            clk_5x_i,
    input  logic            rst_i,

    output logic [3:0][1:0] tmds_o,
    output logic            de_o,
    output logic            hsync_o,
    output logic            vsync_o
);

logic [23:0] pixel;

video_timing #(
    .H_ACTIVE  (H_ACTIVE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_ACTIVE  (V_ACTIVE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK),
    .HSYNC_POS (HSYNC_POS),
    .VSYNC_POS (VSYNC_POS)
) video_timing (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .de_o    (de_o),
    .hsync_o (hsync_o),
    .vsync_o (vsync_o),
    .pixel_o (pixel)
);

dvi_tx dvi_tx (
    .clk_i    (clk_i),
    .clk_5x_i (clk_5x_i),
    .rst_i    (rst_i),
    .de_i     (de_o),
    .hsync_i  (hsync_o),
    .vsync_i  (vsync_o),
    .pixel_i  (pixel),
    .tmds_o   (tmds_o)
);

endmodule

//--- bench/dvi_props.sv
// Concurrent checks on the TMDS encoder, bound into every tmds_encoder instance of the design
`timescale 1ns/10ps

module dvi_props (
    input logic                       clk_i,
    input logic                       rst_i,
    input logic                       de_i,
    input logic [dvi_pkg::TMDS_W-1:0] q_i,
    input dvi_pkg::disparity_t        disparity_i
);

import dvi_pkg::*;

logic is_ctrl;

assign is_ctrl = (q_i == CTRL_00) || (q_i == CTRL_01) || (q_i == CTRL_10) || (q_i == CTRL_11);

// The running disparity never drifts more than ten bits either way
disparity_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
    (disparity_i >= -10) && (disparity_i <= 10))
    else $error("TMDS running disparity out of range: %0d", disparity_i);

// Blanking on the input shows up as a control character two clocks later
ctrl_in_blanking: assert property (@(posedge clk_i) disable iff (rst_i)
    !de_i |-> ##2 is_ctrl)
    else $error("TMDS word %b is not a control character during blanking", q_i);

ctrl00_after_reset: assert property (@(posedge clk_i)
    rst_i |=> (q_i == CTRL_00))
    else $error("TMDS word %b after reset is not CTRL_00", q_i);

endmodule

bind tmds_encoder dvi_props props (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .de_i        (de_i),
    .q_i         (q_o),
    .disparity_i (disparity)
);

//--- bench/dvi_tb.sv
// Directed testbench for dvi_system that recovers the TMDS lanes and checks raster, control and pixels
`timescale 1ns/10ps

module dvi_tb;

import dvi_pkg::*;

localparam int H_ACTIVE = 16;
localparam int H_FRONT  = 2;
localparam int H_SYNC   = 3;
localparam int H_BACK   = 3;
localparam int V_ACTIVE = 4;
localparam int V_FRONT  = 1;
localparam int V_SYNC   = 1;
localparam int V_BACK   = 1;
localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
localparam int TIMEOUT  = 2 * H_TOTAL * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);

logic                   clk_i;
logic                   clk_5x_i;
logic                   rst_i;
logic [3:0][1:0]        tmds_o;
logic                   de_o;
logic                   hsync_o;
logic                   vsync_o;

int                     errors = 0;
int                     live = 0;       // Counts pixel periods with rst_i low and saturates at 3
logic [2:0]             hist [0:3];     // Entries are {vsync, hsync, de} and entry 3 is oldest
logic [2:0]             prev = 3'b000;
logic [3:0][TMDS_W-1:0] rx_word;
int                     pix_cnt = 0;
int                     disp [0:2];
int                     de_run = 0;
int                     hs_run = 0;
int                     vs_run = 0;
int                     line_len = 0;
int                     act_lines = 0;
bit                     line_seen = 1'b0;
int                     de_runs = 0;
int                     pixels = 0;

initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
end

// Every fifth rising edge lines up with a rising edge of clk_i
initial begin
    clk_5x_i = 1'b0;
    forever #4 clk_5x_i = ~clk_5x_i;
end

dvi_system #(
    .H_ACTIVE  (H_ACTIVE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_ACTIVE  (V_ACTIVE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK),
    .HSYNC_POS (1'b1),
    .VSYNC_POS (1'b1)
) UUT (
    .clk_i    (clk_i),
    .clk_5x_i (clk_5x_i),
    .rst_i    (rst_i),
    .tmds_o   (tmds_o),
    .de_o     (de_o),
    .hsync_o  (hsync_o),
    .vsync_o  (vsync_o)
);

task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
        errors++;
        $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
endtask

// Undo the optional inversion, then the XOR or XNOR chain
function automatic logic [7:0] tmds_decode(input logic [TMDS_W-1:0] w);
    logic [7:0] b;
    logic [7:0] d;
    b = w[9] ? ~w[7:0] : w[7:0];
    d[0] = b[0];
    for (int i = 1; i < 8; i++) begin
        d[i] = w[8] ? (b[i] ^ b[i-1]) : ~(b[i] ^ b[i-1]);
    end
    return d;
endfunction

function automatic int ones_minus_zeros(input logic [TMDS_W-1:0] w);
    int n;
    n = 0;
    for (int i = 0; i < TMDS_W; i++) begin
        n = n + (w[i] ? 1 : -1);
    end
    return n;
endfunction

function automatic logic [TMDS_W-1:0] ctrl_symbol(input logic c1, input logic c0);
    case ({c1, c0})
        2'b00:   return CTRL_00;
        2'b01:   return CTRL_01;
        2'b10:   return CTRL_10;
        default: return CTRL_11;
    endcase
endfunction

// Eight equal bars across the active line given as {r, g, b}
function automatic logic [23:0] bar_colour(input int pix);
    case (pix / (H_ACTIVE / 8))
        0:       return 24'hFFFFFF;
        1:       return 24'hFFFF00;
        2:       return 24'h00FFFF;
        3:       return 24'h00FF00;
        4:       return 24'hFF00FF;
        5:       return 24'hFF0000;
        6:       return 24'h0000FF;
        default: return 24'h000000;
    endcase
endfunction

function automatic string chan_name(input int ch);
    case (ch)
        CH_BLUE:  return "blue";
        CH_GREEN: return "green";
        default:  return "red";
    endcase
endfunction

// Line, sync and frame bookkeeping on the raster outputs
task automatic track_raster();
    line_len++;
    if (de_o) begin
        de_run++;
    end else if (prev[0]) begin
        check_value("de_o high run", H_ACTIVE, de_run);
        de_run = 0;
        de_runs++;
    end
    if (hsync_o) begin
        if (!prev[1]) begin
            if (line_seen) begin
                check_value("line period", H_TOTAL, line_len);
            end
            line_seen = 1'b1;
            line_len  = 0;
        end
        hs_run++;
    end else if (prev[1]) begin
        check_value("hsync_o active run", H_SYNC, hs_run);
        hs_run = 0;
    end
    if (de_o && !prev[0]) begin
        act_lines++;
    end
    if (vsync_o) begin
        if (!prev[2]) begin
            check_value("active lines per frame", V_ACTIVE, act_lines);
            act_lines = 0;
        end
        vs_run++;
    end else if (prev[2]) begin
        check_value("vsync_o active run", V_SYNC * H_TOTAL, vs_run);
        vs_run = 0;
    end
    prev = {vsync_o, hsync_o, de_o};
endtask

// Compares one recovered word per lane with the raster state of three periods ago
task automatic check_lanes();
    logic [23:0] exp;
    check_value("clock lane", CLK_LANE_WORD, rx_word[LANE_CLK]);
    if (!hist[3][0]) begin
        if (pix_cnt != 0) begin
            check_value("pixels per line", H_ACTIVE, pix_cnt);
            for (int ch = 0; ch < 3; ch++) begin
                check_value({chan_name(ch), " disparity at line end"}, 0, disp[ch]);
                disp[ch] = 0;
            end
        end
        pix_cnt = 0;
        check_value("blue control", ctrl_symbol(hist[3][2], hist[3][1]), rx_word[CH_BLUE]);
        check_value("green control", CTRL_00, rx_word[CH_GREEN]);
        check_value("red control", CTRL_00, rx_word[CH_RED]);
    end else begin
        exp = bar_colour(pix_cnt);
        for (int ch = 0; ch < 3; ch++) begin
            check_value($sformatf("%s pixel %0d", chan_name(ch), pix_cnt),
                        exp[8*ch +: 8], tmds_decode(rx_word[ch]));
            disp[ch] = disp[ch] + ones_minus_zeros(rx_word[ch]);
            if (disp[ch] > 10 || disp[ch] < -10) begin
                errors++;
                $display("Running disparity of the %s lane went past ten at %0t",
                         chan_name(ch), $time);
            end
        end
        pix_cnt++;
        pixels++;
    end
endtask

// The deserializer takes five bit pairs per lane in the middle of each fast cycle
always @(posedge clk_i) begin
    for (int s = 0; s < 5; s++) begin
        @(negedge clk_5x_i);
        if (s == 0) begin
            hist[3] = hist[2];
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = {vsync_o, hsync_o, de_o};
            if (rst_i) begin
                live      = 0;
                pix_cnt   = 0;
                disp      = '{0, 0, 0};
                de_run    = 0;
                hs_run    = 0;
                vs_run    = 0;
                act_lines = 0;
                line_seen = 1'b0;
                prev      = 3'b000;
            end else begin
                if (live < 3) begin
                    live++;
                end
                track_raster();
            end
        end
        for (int l = 0; l < 4; l++) begin
            rx_word[l][2*s +: 2] = tmds_o[l];
        end
    end
    if (live == 3) begin
        check_lanes();
    end
end

task automatic apply_reset();
    @(posedge clk_i);
    rst_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
endtask

// Select 0 is de_o, 1 is hsync_o, 2 is vsync_o
task automatic wait_level(input string name, input int sel, input logic level);
    int   n;
    logic v;
    n = 0;
    v = ~level;
    while (v != level && n < TIMEOUT) begin
        @(negedge clk_i);
        v = (sel == 0) ? de_o : ((sel == 1) ? hsync_o : vsync_o);
        n++;
    end
    if (v != level) begin
        errors++;
        $display("Timed out waiting for %s to go to %0b", name, level);
    end
endtask

task automatic run_frames(input int n);
    int runs0;
    int pixels0;
    runs0   = de_runs;
    pixels0 = pixels;
    for (int f = 0; f < n; f++) begin
        wait_level("vsync_o", 2, 1'b1);
        wait_level("vsync_o", 2, 1'b0);
    end
    check_value("de_o runs", runs0 + n * V_ACTIVE, de_runs);
    check_value("active pixel words", pixels0 + n * V_ACTIVE * H_ACTIVE, pixels);
endtask

task automatic test_video_stream();
    apply_reset();
    run_frames(2);
endtask

// Reset in the second line of a frame, then one full frame from scratch
task automatic test_mid_frame_reset();
    wait_level("de_o", 0, 1'b1);
    wait_level("de_o", 0, 1'b0);
    wait_level("de_o", 0, 1'b1);
    @(posedge clk_i);
    rst_i <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("de_o in reset", 0, de_o);
    check_value("hsync_o in reset", 0, hsync_o);
    check_value("vsync_o in reset", 0, vsync_o);
    check_value("tmds_o in reset", 0, tmds_o);
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    run_frames(1);
endtask

initial begin
    rst_i = 1'b1;
    test_video_stream();
    test_mid_frame_reset();
    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

//--- sources.f
logic/dvi_pkg.sv
logic/video_timing.sv
logic/tmds_encoder.sv
logic/tmds_serializer.sv
logic/dvi_tx.sv
logic/dvi_system.sv
bench/dvi_props.sv
bench/dvi_tb.sv

//--- Makefile
# Verilator flow for the DVI transmitter: lint the RTL, build and run the testbench

VERILATOR  ?= verilator
TOP        ?= dvi_tb
RTL_TOP    ?= dvi_system
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
FAIL_MSG   ?= Something failed
PASS_MSG   ?= Everything OK

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter logic/%,$(SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
